//--- src/stall_prof_pkg.sv
// Core stall profiler shared types

package stall_prof_pkg;

  // Stall reasons, highest priority first
  typedef enum logic [4:0]
  {
    e_fe_cmd,
    e_fe_cmd_fence,
    e_mispredict,
    e_exception,
    e_interrupt,
    e_special,
    e_itlb_miss,
    e_ic_miss,
    e_dtlb_miss,
    e_dc_miss,
    e_dc_fail,
    e_br_ovr,
    e_ret_ovr,
    e_jal_ovr,
    e_control_haz,
    e_data_haz,
    e_struct_haz,
    e_long_haz,
    e_unknown,
    e_instr
  } stall_reason_e;

  // One bit per reason, e_fe_cmd in the MSB
  typedef struct packed
  {
    logic fe_cmd;
    logic fe_cmd_fence;
    logic mispredict;
    logic exception;
    logic interrupt;
    logic special;
    logic itlb_miss;
    logic ic_miss;
    logic dtlb_miss;
    logic dc_miss;
    logic dc_fail;
    logic br_ovr;
    logic ret_ovr;
    logic jal_ovr;
    logic control_haz;
    logic data_haz;
    logic struct_haz;
    logic long_haz;
  } stall_vec_t;

  localparam int NUM_REASONS = $bits(stall_vec_t);

  typedef enum logic [1:0]
  {
    e_fe_attaboy,
    e_fe_redirect,
    e_fe_br_mispredict,
    e_fe_other
  } fe_cmd_op_e;

  typedef struct packed
  {
    logic       cmd_yumi;
    fe_cmd_op_e cmd_op;
    logic       br_ovr;
    logic       ret_ovr;
    logic       jal_ovr;
    logic       icache_miss;
    logic       icache_tl_we;
    logic       icache_tv_we;
  } fe_event_t;

  typedef struct packed
  {
    logic fe_queue_empty;
    logic suppress_iss;
    logic clear_iss;
    logic mispredict;
    logic data_haz;
    logic control_haz;
    logic struct_haz;
    logic long_haz;
  } isd_event_t;

  typedef struct packed
  {
    logic instret;
    logic exception;
    logic interrupt;
    logic special;
    logic br_mispredict;
    logic itlb_miss;
    logic icache_miss;
    logic dtlb_miss;
    logic dcache_miss;
    logic dcache_replay;
  } commit_info_t;

endpackage

//--- src/stall_prof_ctrl.sv
// Profiler enable and cycle count
`timescale 1ns/1ps

module stall_prof_ctrl
#(
  parameter int FREEZE_DELAY = 8,
  parameter int CYCLE_W      = 30
)
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               freeze_i,
  output logic               prof_en_o,
  output logic [CYCLE_W-1:0] cycle_o
);

  logic [FREEZE_DELAY-1:0] freeze_q;
  logic [CYCLE_W-1:0]      cycle_q;

  // Chain comes out of reset frozen so enable waits the full delay
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      freeze_q <= '1;
    end
    else
    begin
      freeze_q <= (freeze_q << 1) | FREEZE_DELAY'(freeze_i);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cycle_q <= '0;
    end
    else
    begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  assign prof_en_o = ~freeze_q[FREEZE_DELAY-1];
  assign cycle_o   = cycle_q;

endmodule

//--- src/fe_stall_stages.sv
// Front-end stall slots IF0 to IF2
`timescale 1ns/1ps

module fe_stall_stages
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  stall_prof_pkg::fe_event_t fe_event_i,
  output stall_prof_pkg::stall_vec_t if2_vec_o
);

  import stall_prof_pkg::*;

  stall_vec_t if1_n;
  stall_vec_t if1_q;
  stall_vec_t if2_n;
  stall_vec_t if2_q;
  logic       cmd_nonattaboy;
  logic       cmd_br_mispredict;

  // Command classification
  assign cmd_nonattaboy    = fe_event_i.cmd_yumi & (fe_event_i.cmd_op != e_fe_attaboy);
  assign cmd_br_mispredict = fe_event_i.cmd_yumi & (fe_event_i.cmd_op == e_fe_br_mispredict);

  // IF0 never carries a reason so a tl_we empties IF1
  always_comb
  begin
    if1_n             = fe_event_i.icache_tl_we ? '0 : if1_q;
    if1_n.fe_cmd     |= cmd_nonattaboy & ~cmd_br_mispredict;
    if1_n.mispredict |= cmd_br_mispredict;
    if1_n.br_ovr     |= fe_event_i.br_ovr;
    if1_n.ret_ovr    |= fe_event_i.ret_ovr;
    if1_n.jal_ovr    |= fe_event_i.jal_ovr;

    if2_n             = fe_event_i.icache_tv_we ? if1_q : if2_q;
    if2_n.fe_cmd     |= cmd_nonattaboy & ~cmd_br_mispredict;
    if2_n.mispredict |= cmd_br_mispredict;
    if2_n.ic_miss    |= fe_event_i.icache_miss;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      if1_q <= '0;
      if2_q <= '0;
    end
    else
    begin
      if1_q <= if1_n;
      if2_q <= if2_n;
    end
  end

  assign if2_vec_o = if2_q;

endmodule

//--- src/be_stall_stages.sv
// Back-end stall slots ISD to EX3
`timescale 1ns/1ps

module be_stall_stages
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  stall_prof_pkg::stall_vec_t   if2_vec_i,
  input  stall_prof_pkg::isd_event_t   isd_event_i,
  input  stall_prof_pkg::commit_info_t commit_i,
  output stall_prof_pkg::stall_vec_t   ex3_vec_o
);

  import stall_prof_pkg::*;

  stall_vec_t cmt_vec;
  stall_vec_t isd_n;
  stall_vec_t isd_q;
  stall_vec_t ex1_q;
  stall_vec_t ex2_q;
  logic       mispredict_q;

  // Pending mispredict, set wins over clear
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mispredict_q <= 1'b0;
    end
    else if (isd_event_i.mispredict)
    begin
      mispredict_q <= 1'b1;
    end
    else if (isd_event_i.clear_iss)
    begin
      mispredict_q <= 1'b0;
    end
  end

  // Commit events map onto the reason vector
  always_comb
  begin
    cmt_vec            = '0;
    cmt_vec.exception  = commit_i.exception;
    cmt_vec.interrupt  = commit_i.interrupt;
    cmt_vec.special    = commit_i.special;
    cmt_vec.mispredict = commit_i.br_mispredict;
    cmt_vec.itlb_miss  = commit_i.itlb_miss;
    cmt_vec.ic_miss    = commit_i.icache_miss;
    cmt_vec.dtlb_miss  = commit_i.dtlb_miss;
    cmt_vec.dc_miss    = commit_i.dcache_miss;
    cmt_vec.dc_fail    = commit_i.dcache_replay;
  end

  always_comb
  begin
    // Front-end reasons only count while the queue is starved
    isd_n               = isd_event_i.fe_queue_empty ? if2_vec_i : '0;
    isd_n.fe_cmd_fence |= isd_event_i.suppress_iss & ~mispredict_q;
    isd_n.mispredict   |= isd_event_i.mispredict | (isd_event_i.suppress_iss & mispredict_q);
    isd_n.data_haz     |= isd_event_i.data_haz;
    isd_n.control_haz  |= isd_event_i.control_haz;
    isd_n.struct_haz   |= isd_event_i.struct_haz;
    isd_n.long_haz     |= isd_event_i.long_haz;
    isd_n               = isd_n | cmt_vec;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      isd_q <= '0;
      ex1_q <= '0;
      ex2_q <= '0;
    end
    else
    begin
      isd_q <= isd_n;
      ex1_q <= isd_q | cmt_vec;
      ex2_q <= ex1_q | cmt_vec;
    end
  end

  // Special does not land in EX3
  always_comb
  begin
    ex3_vec_o         = ex2_q | cmt_vec;
    ex3_vec_o.special = ex2_q.special;
  end

endmodule

//--- src/stall_reason_encode.sv
// EX3 reason encoder and sample register
`timescale 1ns/1ps

module stall_reason_encode
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          prof_en_i,
  input  stall_prof_pkg::stall_vec_t    ex3_vec_i,
  input  logic                          instret_i,
  output logic                          sample_v_o,
  output stall_prof_pkg::stall_reason_e sample_reason_o
);

  import stall_prof_pkg::*;

  stall_reason_e reason;
  logic          sample_v_q;
  stall_reason_e sample_reason_q;

  // Walk LSB to MSB so the highest-priority bit is written last
  always_comb
  begin
    reason = e_unknown;
    for (int i = 0; i < NUM_REASONS; i++)
    begin
      if (ex3_vec_i[i])
      begin
        reason = stall_reason_e'(5'(NUM_REASONS - 1 - i));
      end
    end
    if (instret_i)
    begin
      reason = e_instr;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      sample_v_q <= 1'b0;
    end
    else
    begin
      sample_v_q <= prof_en_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (prof_en_i)
    begin
      sample_reason_q <= reason;
    end
  end

  assign sample_v_o      = sample_v_q;
  assign sample_reason_o = sample_reason_q;

endmodule

//--- src/stall_histogram.sv
// Per-reason stall counters
`timescale 1ns/1ps

module stall_histogram
#(
  parameter int CNT_W = 32
)
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          clear_i,
  input  logic                          sample_v_i,
  input  stall_prof_pkg::stall_reason_e sample_reason_i,
  input  stall_prof_pkg::stall_reason_e rd_reason_i,
  output logic [CNT_W-1:0]              rd_count_o
);

  import stall_prof_pkg::*;

  // Stall reasons plus e_unknown, retired cycles are not counted
  localparam int NUM_CNT = NUM_REASONS + 1;

  logic [CNT_W-1:0] cnt_q [NUM_CNT];
  logic             inc;

  assign inc = sample_v_i && (sample_reason_i != e_instr);

  always_ff @(posedge clk_i)
  begin
    if (rst_i || clear_i)
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        cnt_q[i] <= '0;
      end
    end
    else if (inc)
    begin
      // Saturate at all ones
      if (cnt_q[sample_reason_i] != '1)
      begin
        cnt_q[sample_reason_i] <= cnt_q[sample_reason_i] + 1'b1;
      end
    end
  end

  always_comb
  begin
    rd_count_o = '0;
    if (int'(rd_reason_i) < NUM_CNT)
    begin
      rd_count_o = cnt_q[rd_reason_i];
    end
  end

endmodule

//--- src/core_stall_profiler.sv
// Core stall profiler top
`timescale 1ns/1ps

module core_stall_profiler
#(
  parameter int CYCLE_W      = 30,
  parameter int CNT_W        = 32,
  parameter int FREEZE_DELAY = 8
)
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          freeze_i,
  input  logic                          clear_i,
  input  stall_prof_pkg::fe_event_t     fe_event_i,
  input  stall_prof_pkg::isd_event_t    isd_event_i,
  input  stall_prof_pkg::commit_info_t  commit_i,
  input  stall_prof_pkg::stall_reason_e rd_reason_i,
  output logic [CNT_W-1:0]              rd_count_o,
  output logic                          sample_v_o,
  output stall_prof_pkg::stall_reason_e sample_reason_o,
  output logic [CYCLE_W-1:0]            sample_cycle_o
);

  import stall_prof_pkg::*;

  logic       prof_en;
  stall_vec_t if2_vec;
  stall_vec_t ex3_vec;

  stall_prof_ctrl #(
    .FREEZE_DELAY(FREEZE_DELAY),
    .CYCLE_W     (CYCLE_W)
  ) u_ctrl (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .freeze_i (freeze_i),
    .prof_en_o(prof_en),
    .cycle_o  (sample_cycle_o)
  );

  fe_stall_stages u_fe (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .fe_event_i(fe_event_i),
    .if2_vec_o (if2_vec)
  );

  be_stall_stages u_be (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .if2_vec_i  (if2_vec),
    .isd_event_i(isd_event_i),
    .commit_i   (commit_i),
    .ex3_vec_o  (ex3_vec)
  );

  stall_reason_encode u_encode (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .prof_en_i      (prof_en),
    .ex3_vec_i      (ex3_vec),
    .instret_i      (commit_i.instret),
    .sample_v_o     (sample_v_o),
    .sample_reason_o(sample_reason_o)
  );

  stall_histogram #(
    .CNT_W(CNT_W)
  ) u_hist (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .clear_i        (clear_i),
    .sample_v_i     (sample_v_o),
    .sample_reason_i(sample_reason_o),
    .rd_reason_i    (rd_reason_i),
    .rd_count_o     (rd_count_o)
  );

endmodule

//--- verif/tb_core_stall_profiler.sv
// Core stall profiler testbench
`timescale 1ns/1ps

module tb_core_stall_profiler;

  import stall_prof_pkg::*;

  localparam int CYCLE_W      = 30;
  localparam int CNT_W        = 32;
  localparam int FREEZE_DELAY = 8;
  localparam int RESET_CYCLES = 16;
  localparam int HIST_LEN     = 64;
  localparam int NUM_CODES    = NUM_REASONS + 2;

  // Cycle budget per test with twice the sum as the limit
  localparam int SETUP_CYCLES  = RESET_CYCLES + 5 * FREEZE_DELAY + 8;
  localparam int ISSUE_CYCLES  = 5 * 12;
  localparam int COMMIT_CYCLES = 4 * 12;
  localparam int FE_CYCLES     = 5 * 16;
  localparam int HIST_CYCLES   = HIST_LEN + 20;
  localparam int CLEAR_CYCLES  = 12;
  localparam int MAX_CYCLES    = 2 * (SETUP_CYCLES + ISSUE_CYCLES + COMMIT_CYCLES
                                      + FE_CYCLES + HIST_CYCLES + CLEAR_CYCLES);

  logic               clk_i;
  logic               rst_i;
  logic               freeze_i;
  logic               clear_i;
  fe_event_t          fe_event_i;
  isd_event_t         isd_event_i;
  commit_info_t       commit_i;
  stall_reason_e      rd_reason_i;
  logic [CNT_W-1:0]   rd_count_o;
  logic               sample_v_o;
  stall_reason_e      sample_reason_o;
  logic [CYCLE_W-1:0] sample_cycle_o;

  logic [15:0]        lfsr_state;
  int unsigned        model_cnt [NUM_CODES];
  stall_reason_e      exp_q [$];
  // Reason given by each hazard bit of isd_event_t
  stall_reason_e      haz_reason [4];
  int                 cycle_cnt;

  core_stall_profiler #(
    .CYCLE_W     (CYCLE_W),
    .CNT_W       (CNT_W),
    .FREEZE_DELAY(FREEZE_DELAY)
  ) u_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .freeze_i       (freeze_i),
    .clear_i        (clear_i),
    .fe_event_i     (fe_event_i),
    .isd_event_i    (isd_event_i),
    .commit_i       (commit_i),
    .rd_reason_i    (rd_reason_i),
    .rd_count_o     (rd_count_o),
    .sample_v_o     (sample_v_o),
    .sample_reason_o(sample_reason_o),
    .sample_cycle_o (sample_cycle_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #5 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      report_failure($sformatf("Timeout: the tests did not finish within %0d cycles",
                               MAX_CYCLES));
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic logic lfsr_take_bit();
    logic fb;
    fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  // All single-cycle inputs drop back to zero
  task automatic next_cycle();
    tick();
    clear_i     = 1'b0;
    fe_event_i  = '0;
    isd_event_i = '0;
    commit_i    = '0;
  endtask

  task automatic check_reason(input stall_reason_e exp, input string what);
    assert (sample_v_o && sample_reason_o == exp)
    else
    begin
      report_failure($sformatf("** Error at %0t: %s, expected reason %0d, got %0d (valid %0b)",
                               $time, what, exp, sample_reason_o, sample_v_o));
    end
  endtask

  task automatic expect_after(input int lat, input stall_reason_e exp, input string what);
    repeat (lat)
    begin
      next_cycle();
    end
    check_reason(exp, what);
  endtask

  task automatic drain();
    repeat (6)
    begin
      next_cycle();
    end
    check_reason(e_unknown, "idle pipeline");
  endtask

  task automatic check_valid_for(input logic exp_v, input int cycles);
    repeat (cycles)
    begin
      assert (sample_v_o == exp_v)
      else
      begin
        report_failure($sformatf("** Error at %0t: sample valid expected %0b, got %0b",
                                 $time, exp_v, sample_v_o));
      end
      tick();
    end
  endtask

  // Walks the read port within one cycle
  task automatic check_counts(input string what);
    for (int i = 0; i < NUM_CODES; i++)
    begin
      rd_reason_i = stall_reason_e'(i);
      #0.3;
      assert (rd_count_o == model_cnt[i])
      else
      begin
        report_failure($sformatf("** Error at %0t: %s, count %0d expected %0d, got %0d",
                                 $time, what, i, model_cnt[i], rd_count_o));
      end
    end
  endtask

  task automatic pulse_clear();
    next_cycle();
    clear_i = 1'b1;
    for (int i = 0; i < NUM_CODES; i++)
    begin
      model_cnt[i] = 0;
    end
  endtask

  task automatic count_sample(input stall_reason_e exp);
    check_reason(exp, "histogram sample");
    if (exp != e_instr)
    begin
      model_cnt[exp]++;
    end
  endtask

  task automatic test_reset_and_freeze();
    repeat (RESET_CYCLES)
    begin
      tick();
    end
    rst_i = 1'b0;
    check_counts("after reset");
    check_valid_for(1'b0, FREEZE_DELAY + 1);
    assert (sample_cycle_o == CYCLE_W'(FREEZE_DELAY + 1))
    else
    begin
      report_failure($sformatf("** Error at %0t: cycle count expected %0d, got %0d",
                               $time, FREEZE_DELAY + 1, sample_cycle_o));
    end
    check_valid_for(1'b1, 2);
    freeze_i = 1'b1;
    check_valid_for(1'b1, FREEZE_DELAY + 1);
    check_valid_for(1'b0, 2 * FREEZE_DELAY);
    freeze_i = 1'b0;
    check_valid_for(1'b0, FREEZE_DELAY + 1);
    check_valid_for(1'b1, 1);
  endtask

  task automatic test_issue_priority();
    drain();
    next_cycle();
    isd_event_i.data_haz   = 1'b1;
    isd_event_i.struct_haz = 1'b1;
    expect_after(4, e_data_haz, "data and struct hazard");
    drain();
    next_cycle();
    isd_event_i.suppress_iss = 1'b1;
    expect_after(4, e_fe_cmd_fence, "suppress without mispredict");
    drain();
    next_cycle();
    isd_event_i.mispredict = 1'b1;
    expect_after(4, e_mispredict, "issue mispredict");
    drain();
    next_cycle();
    isd_event_i.suppress_iss = 1'b1;
    expect_after(4, e_mispredict, "suppress after mispredict");
    drain();
    next_cycle();
    isd_event_i.clear_iss = 1'b1;
    next_cycle();
    isd_event_i.suppress_iss = 1'b1;
    expect_after(4, e_fe_cmd_fence, "suppress after clear");
  endtask

  task automatic test_commit_events();
    drain();
    next_cycle();
    commit_i.exception = 1'b1;
    expect_after(1, e_exception, "commit exception");
    drain();
    next_cycle();
    isd_event_i.data_haz = 1'b1;
    repeat (3)
    begin
      next_cycle();
    end
    commit_i.interrupt = 1'b1;
    expect_after(1, e_interrupt, "interrupt over data hazard in flight");
    drain();
    next_cycle();
    commit_i.special = 1'b1;
    expect_after(1, e_unknown, "special left out of EX3");
    expect_after(1, e_special, "special through EX2");
    drain();
    // Retire sample follows the clear so every counter must stay at zero
    pulse_clear();
    commit_i.instret = 1'b1;
    next_cycle();
    check_reason(e_instr, "retired instruction");
    next_cycle();
    check_counts("after retire");
  endtask

  // Zero IF1 then move the zero slot into IF2
  task automatic flush_fe();
    next_cycle();
    fe_event_i.icache_tl_we = 1'b1;
    next_cycle();
    fe_event_i.icache_tv_we = 1'b1;
  endtask

  task automatic test_front_end();
    drain();
    next_cycle();
    fe_event_i.cmd_yumi = 1'b1;
    fe_event_i.cmd_op   = e_fe_attaboy;
    next_cycle();
    isd_event_i.fe_queue_empty = 1'b1;
    expect_after(4, e_unknown, "attaboy command");
    next_cycle();
    fe_event_i.cmd_yumi = 1'b1;
    fe_event_i.cmd_op   = e_fe_redirect;
    next_cycle();
    isd_event_i.fe_queue_empty = 1'b1;
    expect_after(4, e_fe_cmd, "redirect command");
    flush_fe();
    drain();
    next_cycle();
    fe_event_i.br_ovr = 1'b1;
    next_cycle();
    isd_event_i.fe_queue_empty = 1'b1;
    expect_after(4, e_unknown, "override still in IF1");
    next_cycle();
    fe_event_i.icache_tv_we = 1'b1;
    next_cycle();
    isd_event_i.fe_queue_empty = 1'b1;
    expect_after(4, e_br_ovr, "override moved to IF2");
    flush_fe();
    drain();
    next_cycle();
    fe_event_i.icache_miss  = 1'b1;
    fe_event_i.icache_tv_we = 1'b1;
    drain();
    next_cycle();
    isd_event_i.fe_queue_empty = 1'b1;
    expect_after(4, e_ic_miss, "icache miss held in IF2");
    flush_fe();
  endtask

  task automatic test_histogram();
    logic [1:0] pick;
    drain();
    pulse_clear();
    exp_q = {};
    repeat (4)
    begin
      exp_q.push_back(e_unknown);
    end
    for (int n = 0; n < HIST_LEN + 4; n++)
    begin
      next_cycle();
      count_sample(exp_q.pop_front());
      if (n < HIST_LEN)
      begin
        pick[1]           = lfsr_take_bit();
        pick[0]           = lfsr_take_bit();
        isd_event_i[pick] = 1'b1;
        exp_q.push_back(haz_reason[pick]);
      end
    end
    next_cycle();
    check_counts("histogram");
  endtask

  task automatic test_clear();
    drain();
    pulse_clear();
    next_cycle();
    check_counts("after clear");
    next_cycle();
    model_cnt[e_unknown] = 1;
    check_counts("first sample after clear");
  endtask

  initial
  begin
    rst_i       = 1'b1;
    freeze_i    = 1'b0;
    clear_i     = 1'b0;
    fe_event_i  = '0;
    isd_event_i = '0;
    commit_i    = '0;
    rd_reason_i = e_fe_cmd;
    lfsr_state  = 16'd42016;
    cycle_cnt   = 0;
    haz_reason  = '{e_long_haz, e_struct_haz, e_control_haz, e_data_haz};
    for (int i = 0; i < NUM_CODES; i++)
    begin
      model_cnt[i] = 0;
    end

    test_reset_and_freeze();
    test_issue_priority();
    test_commit_events();
    test_front_end();
    test_histogram();
    test_clear();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- sim.f
src/stall_prof_pkg.sv
src/stall_prof_ctrl.sv
src/fe_stall_stages.sv
src/be_stall_stages.sv
src/stall_reason_encode.sv
src/stall_histogram.sv
src/core_stall_profiler.sv
verif/tb_core_stall_profiler.sv

//--- Bender.yml
package:
  name: core_stall_profiler

sources:
  - src/stall_prof_pkg.sv
  - src/stall_prof_ctrl.sv
  - src/fe_stall_stages.sv
  - src/be_stall_stages.sv
  - src/stall_reason_encode.sv
  - src/stall_histogram.sv
  - src/core_stall_profiler.sv
  - target: test
    files:
      - verif/tb_core_stall_profiler.sv
